//--- all.f
hdl/link_pkg.sv
hdl/frame_pkg.sv
hdl/rx_frame_aligner.sv
hdl/link_monitor.sv
hdl/comp_data_out.sv
hdl/dcfeb_optical_rx.sv
verif/tb_dcfeb_optical_rx.sv

//--- Bender.yml
package:
  name: dcfeb_optical_rx

sources:
  # Packages first, then the blocks, then the top level
  - files:
      - hdl/link_pkg.sv
      - hdl/frame_pkg.sv
      - hdl/rx_frame_aligner.sv
      - hdl/link_monitor.sv
      - hdl/comp_data_out.sv
      - hdl/dcfeb_optical_rx.sv

  - target: simulation
    files:
      - verif/tb_dcfeb_optical_rx.sv

//--- verif/tb_dcfeb_optical_rx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcfeb_optical_rx;
  import link_pkg::*;
  import frame_pkg::*;

  localparam int DELAY_DEPTH = 16;
  localparam int GOOD_RUN    = 64;
  localparam int BAD_LIMIT   = 16;
  localparam int DW          = $clog2(DELAY_DEPTH);
  localparam int RUN_WORDS   = 4 + 2 * GOOD_RUN + 300;  // Sum of all test lengths in words

  logic          clock;
  logic          gtx_rx_reset;
  logic          ttc_resync;
  rx_word_t      rx_word;
  logic [DW-1:0] delay_is;
  comp_frame_t   gtx_rx_data;
  logic          gtx_rx_data_strobe;
  logic          gtx_rx_start;
  logic          gtx_rx_fc;
  logic          gtx_rx_valid;
  link_status_t  link_status;

  // Reference model state
  link_status_t  m_st;           // Expected monitor status
  int            m_run;          // Clean run length
  logic          m_in;           // Inside a frame
  int            m_n;            // Data words taken
  logic          m_fc;
  comp_frame_t   m_acc;          // Frame being assembled
  comp_frame_t   m_line [DELAY_DEPTH];
  frame_beat_t   exp_q [$];      // Frames expected at the strobe
  frame_beat_t   exp_now;
  int            dly;            // Tap driven onto delay_is
  logic [31:0]   rng;
  int            errors;
  int            checks;
  int            tests;
  int            test_err;       // Error count when the test started

  dcfeb_optical_rx #(
    .DELAY_DEPTH (DELAY_DEPTH),
    .GOOD_RUN    (GOOD_RUN),
    .BAD_LIMIT   (BAD_LIMIT)
  ) dcfeb_optical_rx_inst (
    .clock              (clock),
    .gtx_rx_reset       (gtx_rx_reset),
    .ttc_resync         (ttc_resync),
    .rx_word            (rx_word),
    .delay_is           (delay_is),
    .gtx_rx_data        (gtx_rx_data),
    .gtx_rx_data_strobe (gtx_rx_data_strobe),
    .gtx_rx_start       (gtx_rx_start),
    .gtx_rx_fc          (gtx_rx_fc),
    .gtx_rx_valid       (gtx_rx_valid),
    .link_status        (link_status)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;  // 50 MHz
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // ----------------------------------------
  // Reference model, one call per sent word
  // ----------------------------------------
  function automatic void ref_word(input rx_word_t w, input logic rs);
    logic        hdr;
    logic        err;
    comp_frame_t f;
    hdr = w.is_k && (w.data == K_SOF || w.data == K_FC);
    err = w.disp_err || w.not_in_table;
    if (rs) begin
      m_st  = '0;  // Resync wipes the link history
      m_run = 0;
    end else if (err) begin
      m_st.good    = 1'b0;
      m_st.had_err = 1'b1;
      m_run        = 0;
      if (m_st.err_count != 8'hFF)
        m_st.err_count = m_st.err_count + 8'd1;
      if (w.disp_err && m_st.disperr_count != 16'hFFFF)
        m_st.disperr_count = m_st.disperr_count + 16'd1;
      if (w.not_in_table && m_st.notintable_count != 16'hFFFF)
        m_st.notintable_count = m_st.notintable_count + 16'd1;
      if (m_st.err_count >= BAD_LIMIT)
        m_st.bad = 1'b1;
    end else begin
      if (m_run < GOOD_RUN)
        m_run++;
      if (m_run >= GOOD_RUN)
        m_st.good = 1'b1;
    end
    if (hdr) begin
      m_in = 1'b1;  // Header restarts any partial frame
      m_n  = 0;
      m_fc = (w.data == K_FC);
    end else if (m_in && w.is_k) begin
      m_in = 1'b0;  // Frame dropped
    end else if (m_in) begin
      m_acc = {m_acc[31:0], w.data};
      m_n++;
      if (m_n == 3) begin
        m_in = 1'b0;
        f    = (m_st.good && !m_st.bad) ? m_acc : '0;  // Untrusted link gives zero
        for (int i = DELAY_DEPTH - 1; i > 0; i--)
          m_line[i] = m_line[i-1];
        m_line[0] = f;
        exp_q.push_back('{frame: m_line[dly], valid: 1'b1, fc: m_fc});
      end
    end
  endfunction

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------
  task automatic send_word(input rx_word_t w, input logic rs);
    @(posedge clock);
    rx_word    <= w;
    ttc_resync <= rs;
    delay_is   <= DW'(dly);
    ref_word(w, rs);
  endtask

  task automatic send_k(input logic [15:0] d);
    send_word('{data: d, is_k: 1'b1, disp_err: 1'b0, not_in_table: 1'b0}, 1'b0);
  endtask

  task automatic send_data(input logic [15:0] d, input logic de, input logic nit);
    send_word('{data: d, is_k: 1'b0, disp_err: de, not_in_table: nit}, 1'b0);
  endtask

  task automatic send_rand();
    rng = xorshift(rng);
    send_data(rng[15:0], 1'b0, 1'b0);
  endtask

  task automatic idles(input int n);
    repeat (n) send_k(K_IDLE);
  endtask

  task automatic send_frame(input logic [15:0] hdr);
    send_k(hdr);
    repeat (3) send_rand();
    rng = xorshift(rng);
    idles(1 + rng[20]);  // One or two idles between frames
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_status();
    link_status_t snap;
    snap = m_st;
    idles(2);  // Status reaches the output two clocks after its word
    @(negedge clock);
    check_val("link_status.good", link_status.good, snap.good);
    check_val("link_status.bad", link_status.bad, snap.bad);
    check_val("link_status.had_err", link_status.had_err, snap.had_err);
    check_val("link_status.err_count", link_status.err_count, snap.err_count);
    check_val("link_status.disperr_count", link_status.disperr_count, snap.disperr_count);
    check_val("link_status.notintable_count", link_status.notintable_count,
              snap.notintable_count);
  endtask

  task automatic end_test(input string name);
    idles(4);  // Lets the last strobe come out
    assert (exp_q.size() == 0) else begin
      $display("Missing strobe in %s: %0d frames never came out", name, exp_q.size());
      errors++;
      exp_q.delete();
    end
    tests++;
    $display("Test %0d %s: %0d errors", tests, name, errors - test_err);
    test_err = errors;
  endtask

  // Compares every strobe with the head of the queue
  always @(negedge clock) begin
    if (!gtx_rx_reset && gtx_rx_data_strobe) begin
      assert (exp_q.size() != 0) else begin
        $display("Unexpected strobe at %0t ns with no frame sent for it", $time);
        errors++;
      end
      if (exp_q.size() != 0) begin
        exp_now = exp_q.pop_front();
        check_val("gtx_rx_data", gtx_rx_data, exp_now.frame);
        check_val("gtx_rx_fc", gtx_rx_fc, exp_now.fc);
        check_val("gtx_rx_valid", gtx_rx_valid, 1'b1);
      end
    end
  end

  // Watchdog
  initial begin
    #((RUN_WORDS + 100) * 20);
    $display("Timeout: the run did not finish in its time limit");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    gtx_rx_reset = 1'b1;
    ttc_resync   = 1'b0;
    rx_word      = '{data: K_IDLE, is_k: 1'b1, disp_err: 1'b0, not_in_table: 1'b0};
    delay_is     = '0;
    m_st         = '0;
    m_run        = 0;
    m_in         = 1'b0;
    m_n          = 0;
    m_fc         = 1'b0;
    m_acc        = '0;
    dly          = 0;
    rng          = 32'h5983;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    test_err     = 0;
    for (int i = 0; i < DELAY_DEPTH; i++)
      m_line[i] = '0;
    repeat (3) @(posedge clock);
    send_k(K_IDLE);           // Fourth reset clock, word held after release
    gtx_rx_reset <= 1'b0;

    // ---------------------------------------- reset state and link up
    @(negedge clock);
    check_val("gtx_rx_data_strobe", gtx_rx_data_strobe, 1'b0);
    check_val("gtx_rx_valid", gtx_rx_valid, 1'b0);
    check_val("gtx_rx_fc", gtx_rx_fc, 1'b0);
    check_val("gtx_rx_start", gtx_rx_start, 1'b0);
    check_val("link_status", link_status, '0);
    idles(GOOD_RUN);
    check_status();
    end_test("reset and link up");

    repeat (8) send_frame(K_SOF);
    check_val("gtx_rx_start", gtx_rx_start, 1'b1);
    end_test("random K_SOF frames");

    send_frame(K_FC);
    send_k(K_SOF);            // Cut short by an idle, dropped
    send_rand();
    send_rand();
    idles(2);
    send_k(K_SOF);            // Restarted by a second header
    send_rand();
    send_frame(K_FC);
    end_test("fc header and dropped frame");

    dly = 3;
    repeat (4) send_frame(K_SOF);
    end_test("delay of 3 frames");
    dly = DELAY_DEPTH - 1;
    repeat (6) send_frame(K_SOF);
    end_test("delay of DELAY_DEPTH-1 frames");

    dly = 0;
    repeat (3) send_data(16'h1111, 1'b1, 1'b0);
    repeat (2) send_data(16'h2222, 1'b0, 1'b1);
    send_data(16'h3333, 1'b1, 1'b1);
    repeat (3) send_frame(K_SOF);  // Link untrusted, frames zeroed
    check_status();
    end_test("code errors and gating");

    repeat (5) begin
      send_data(16'h4444, 1'b1, 1'b0);
      send_data(16'h5555, 1'b0, 1'b1);
    end
    send_frame(K_SOF);
    check_status();           // Bad set at BAD_LIMIT
    send_word('{data: K_IDLE, is_k: 1'b1, disp_err: 1'b0, not_in_table: 1'b0}, 1'b1);
    idles(GOOD_RUN);
    check_status();
    end_test("bad limit and resync");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/dcfeb_optical_rx.sv
`timescale 1ns/1ns
`default_nettype none

module dcfeb_optical_rx #(
  parameter int DELAY_DEPTH = 16,  // Crossing delay taps
  parameter int GOOD_RUN    = 64,  // Clean words for link good
  parameter int BAD_LIMIT   = 16   // Errors for link bad
) (
  input  logic                           clock,
  input  logic                           gtx_rx_reset,
  input  logic                           ttc_resync,
  input  link_pkg::rx_word_t             rx_word,
  input  logic [$clog2(DELAY_DEPTH)-1:0] delay_is,
  output frame_pkg::comp_frame_t         gtx_rx_data,
  output logic                           gtx_rx_data_strobe,
  output logic                           gtx_rx_start,
  output logic                           gtx_rx_fc,
  output logic                           gtx_rx_valid,
  output link_pkg::link_status_t         link_status
);
  import link_pkg::*;
  import frame_pkg::*;

  frame_beat_t  beat;    // Aligner to output stage
  link_status_t status;  // Monitor to output stage

  // ----------------------------------------
  // Word stream consumers, side by side
  // ----------------------------------------
  rx_frame_aligner rx_frame_aligner_inst (
    .clock        (clock),
    .gtx_rx_reset (gtx_rx_reset),
    .rx_word      (rx_word),
    .beat         (beat),
    .rx_start     (gtx_rx_start)
  );

  link_monitor #(.GOOD_RUN(GOOD_RUN), .BAD_LIMIT(BAD_LIMIT)) link_monitor_inst (
    .clock        (clock),
    .gtx_rx_reset (gtx_rx_reset),
    .ttc_resync   (ttc_resync),
    .rx_word      (rx_word),
    .status       (status)
  );

  // Quality gate, delay line and output registers
  comp_data_out #(.DELAY_DEPTH(DELAY_DEPTH)) comp_data_out_inst (
    .clock              (clock),
    .gtx_rx_reset       (gtx_rx_reset),
    .beat               (beat),
    .status_in          (status),
    .delay_is           (delay_is),
    .gtx_rx_data        (gtx_rx_data),
    .gtx_rx_data_strobe (gtx_rx_data_strobe),
    .gtx_rx_valid       (gtx_rx_valid),
    .gtx_rx_fc          (gtx_rx_fc),
    .status_out         (link_status)
  );

endmodule

`default_nettype wire

//--- hdl/comp_data_out.sv
`timescale 1ns/1ns
`default_nettype none

module comp_data_out #(
  parameter int DELAY_DEPTH = 16  // Taps in the crossing delay line
) (
  input  logic                               clock,
  input  logic                               gtx_rx_reset,
  input  frame_pkg::frame_beat_t             beat,        // Frame from aligner
  input  link_pkg::link_status_t             status_in,   // Status from monitor
  input  logic [$clog2(DELAY_DEPTH)-1:0]     delay_is,    // Frames of delay, 0 is current
  output frame_pkg::comp_frame_t             gtx_rx_data,
  output logic                               gtx_rx_data_strobe,
  output logic                               gtx_rx_valid,
  output logic                               gtx_rx_fc,
  output link_pkg::link_status_t             status_out
);
  import link_pkg::*;
  import frame_pkg::*;

  comp_frame_t dly_line [DELAY_DEPTH];  // Entry 0 holds newest frame
  comp_frame_t gated;                   // Frame after link quality check
  logic        untrusted;

  // Keep a bad link from feeding hot comparators downstream
  assign untrusted = !status_in.good || status_in.bad;
  assign gated     = untrusted ? '0 : beat.frame;

  // ----------------------------------------
  // Frame rate delay line
  // ----------------------------------------
  // Advances only on a beat, so delay counts frames, not clocks
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      for (int i = 0; i < DELAY_DEPTH; i++)
        dly_line[i] <= '0;  // Unwritten taps read zero
    end else if (beat.valid) begin
      dly_line[0] <= gated;
      for (int i = 1; i < DELAY_DEPTH; i++)
        dly_line[i] <= dly_line[i-1];
    end
  end

  assign gtx_rx_data = dly_line[delay_is];  // Tap select

  // ----------------------------------------
  // Registered flags and status
  // ----------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      gtx_rx_data_strobe <= 1'b0;
      gtx_rx_valid       <= 1'b0;
      gtx_rx_fc          <= 1'b0;
      status_out         <= '0;
    end else begin
      gtx_rx_data_strobe <= beat.valid;  // Same cycle the tap shows the frame
      gtx_rx_valid       <= beat.valid;
      gtx_rx_fc          <= beat.valid && beat.fc;
      status_out         <= status_in;
    end
  end

  // Frame from an untrusted link leaves tap 0 as zero
  a_strobe_gated: assert property (@(posedge clock) disable iff (gtx_rx_reset)
    beat.valid && untrusted |=>
      gtx_rx_data_strobe && (delay_is != '0 || gtx_rx_data == '0));

endmodule

`default_nettype wire

//--- hdl/link_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module link_monitor #(
  parameter int GOOD_RUN  = 64,  // Clean words before good rises
  parameter int BAD_LIMIT = 16   // Error count that latches bad
) (
  input  logic                   clock,
  input  logic                   gtx_rx_reset,
  input  logic                   ttc_resync,  // Clears counters and flags
  input  link_pkg::rx_word_t     rx_word,
  output link_pkg::link_status_t status
);
  import link_pkg::*;

  localparam int RUN_W = $clog2(GOOD_RUN + 1);

  logic             good;
  logic             bad;
  logic             had_err;
  logic [7:0]       err_count;
  logic [15:0]      disperr_count;
  logic [15:0]      notintable_count;
  logic [RUN_W-1:0] run_cnt;  // Consecutive clean words, saturates at GOOD_RUN
  logic             word_err;
  logic [7:0]       err_inc;  // Saturated next error count

  assign word_err = rx_word.disp_err || rx_word.not_in_table;
  assign err_inc  = (err_count == 8'hFF) ? 8'hFF : err_count + 8'd1;

  // ----------------------------------------
  // Counters and flags
  // ----------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      good             <= 1'b0;
      bad              <= 1'b0;
      had_err          <= 1'b0;
      err_count        <= 8'd0;
      disperr_count    <= 16'd0;
      notintable_count <= 16'd0;
      run_cnt          <= '0;
    end else if (ttc_resync) begin
      good             <= 1'b0;  // Link must prove itself again
      bad              <= 1'b0;
      had_err          <= 1'b0;
      err_count        <= 8'd0;
      disperr_count    <= 16'd0;
      notintable_count <= 16'd0;
      run_cnt          <= '0;
    end else if (word_err) begin
      good      <= 1'b0;     // Falls on the clock after a bad word
      had_err   <= 1'b1;
      run_cnt   <= '0;
      err_count <= err_inc;  // One count per word, whatever the flags
      if (int'(err_inc) >= BAD_LIMIT)
        bad <= 1'b1;         // Latched until resync
      if (rx_word.disp_err && disperr_count != 16'hFFFF)
        disperr_count <= disperr_count + 16'd1;
      if (rx_word.not_in_table && notintable_count != 16'hFFFF)
        notintable_count <= notintable_count + 16'd1;
    end else begin
      if (run_cnt != RUN_W'(GOOD_RUN))
        run_cnt <= run_cnt + 1'b1;
      // Rises with the GOOD_RUN-th clean word
      if (run_cnt == RUN_W'(GOOD_RUN - 1))
        good <= 1'b1;
    end
  end

  assign status = '{
    good:             good,
    bad:              bad,
    had_err:          had_err,
    err_count:        err_count,
    disperr_count:    disperr_count,
    notintable_count: notintable_count
  };

  // Error count only moves up between resyncs
  a_err_mono: assert property (@(posedge clock) disable iff (gtx_rx_reset)
    !ttc_resync |=> status.err_count >= $past(status.err_count));

endmodule

`default_nettype wire

//--- hdl/rx_frame_aligner.sv
`timescale 1ns/1ns
`default_nettype none

module rx_frame_aligner (
  input  logic                   clock,
  input  logic                   gtx_rx_reset,
  input  link_pkg::rx_word_t     rx_word,   // Decoded word, one per clock
  output frame_pkg::frame_beat_t beat,      // Assembled frame event
  output logic                   rx_start   // First header seen
);
  import link_pkg::*;
  import frame_pkg::*;

  logic        in_frame;    // Header seen, collecting data words
  logic [1:0]  word_cnt;    // Data words taken so far
  logic        hdr_fc;      // Current frame opened with K_FC
  logic [31:0] partial;     // First two data words
  comp_frame_t frame_q;
  logic        valid_q;
  logic        fc_q;
  logic        hdr_is_fc;
  logic        is_hdr;
  logic        drop;        // Framing error, k-word inside frame

  // Header decode
  assign hdr_is_fc = rx_word.is_k && (rx_word.data == K_FC);
  assign is_hdr    = hdr_is_fc || (rx_word.is_k && (rx_word.data == K_SOF));
  assign drop      = in_frame && rx_word.is_k;

  // ----------------------------------------
  // Framing state
  // ----------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      in_frame <= 1'b0;
      word_cnt <= 2'd0;
      hdr_fc   <= 1'b0;
      valid_q  <= 1'b0;
      fc_q     <= 1'b0;
      rx_start <= 1'b0;
    end else begin
      valid_q <= 1'b0;  // Beat is a one clock pulse
      fc_q    <= 1'b0;
      if (is_hdr) begin
        // Also restarts a frame that a header cut short
        in_frame <= 1'b1;
        word_cnt <= 2'd0;
        hdr_fc   <= hdr_is_fc;
        rx_start <= 1'b1;  // Held until reset
      end else if (drop) begin
        in_frame <= 1'b0;  // Partial frame thrown away
      end else if (in_frame) begin
        if (word_cnt == 2'd2) begin
          in_frame <= 1'b0;  // Third word completes frame
          valid_q  <= 1'b1;
          fc_q     <= hdr_fc;
        end
        word_cnt <= word_cnt + 2'd1;
      end
    end
  end

  // Payload capture, data words only
  always_ff @(posedge clock) begin
    if (in_frame && !rx_word.is_k) begin
      case (word_cnt)
        2'd0:    partial[31:16] <= rx_word.data;
        2'd1:    partial[15:0]  <= rx_word.data;
        default: frame_q        <= {partial, rx_word.data};
      endcase
    end
  end

  assign beat = '{frame: frame_q, valid: valid_q, fc: fc_q};

  // A frame needs a header and three words, so beats never touch
  a_beat_gap: assert property (@(posedge clock) disable iff (gtx_rx_reset)
    beat.valid |=> !beat.valid);

endmodule

`default_nettype wire

//--- hdl/frame_pkg.sv
`default_nettype none

// ----------------------------------------
// Comparator frame definitions
// ----------------------------------------
package frame_pkg;

  // Three data words of one bunch crossing
  //   bits 47:32 first word after header
  //   bits 31:16 second word
  //   bits 15:0  third word
  typedef logic [47:0] comp_frame_t;

  // One assembled frame as it leaves the aligner
  typedef struct packed {
    comp_frame_t frame;  // Comparator bits
    logic        valid;  // Single cycle pulse per frame
    logic        fc;     // Frame had the latency marker header
  } frame_beat_t;

endpackage

`default_nettype wire

//--- hdl/link_pkg.sv
`default_nettype none

// ----------------------------------------
// Word level definitions of the fiber link
// ----------------------------------------
package link_pkg;

  // One decoded word from the transceiver, one per clock
  typedef struct packed {
    logic [15:0] data;          // Decoded byte pair
    logic        is_k;          // Word holds a k-character
    logic        disp_err;      // Running disparity error
    logic        not_in_table;  // Code group not in 8b/10b table
  } rx_word_t;

  // Header and idle codes, valid only with is_k set
  localparam logic [15:0] K_SOF  = 16'h50BC;  // Normal frame header
  localparam logic [15:0] K_FC   = 16'hFCBC;  // Latency marker header
  localparam logic [15:0] K_IDLE = 16'hBCBC;  // Idle comma between frames

  // Link quality as seen by the monitor
  typedef struct packed {
    logic        good;              // Clean run long enough
    logic        bad;               // Error limit reached
    logic        had_err;           // Sticky, any error since resync
    logic [7:0]  err_count;         // Words with any error
    logic [15:0] disperr_count;     // Disparity errors
    logic [15:0] notintable_count;  // Not-in-table errors
  } link_status_t;

endpackage

`default_nettype wire
